//--- tb.f
+incdir+logic
logic/calcPkg.sv
logic/entryControl.sv
logic/operandMemory.sv
logic/calcAlu.sv
logic/segmentDecoder.sv
logic/displayScanner.sv
logic/calcTop.sv
test/calcTb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the calculator testbench; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module calcTb -f tb.f &&
./obj_dir/VcalcTb ||
{ echo "Simulation failed"; exit 1; }

//--- test/calcTb.sv
`timescale 1ns/1ps
`include "calc_consts.svh"

module calcTb import calcPkg::*;
();

	localparam int driveDelay = 10;
	localparam int frameCycles = `CALC_DIGITS * `SCAN_TICKS;

	typedef enum logic [1:0] {
		keyDigit,
		keyOp,
		keyEqual,
		keyClear
	} keyKind_t;

	// One key press and the display it should leave behind
	typedef struct packed {
		keyKind_t kind;
		logic [3:0] data;
		operand_t value;
		logic [`CALC_DIGITS-1:0] blankMask;
	} keyRow_t;

	logic clk;
	logic rstN;
	logic digitStrobe;
	nibble_t digit;
	logic opStrobe;
	opCode_t opCode;
	logic equalStrobe;
	logic clearStrobe;
	segments_t segments;
	logic [`CALC_DIGITS-1:0] anodes;

	keyRow_t keyTable[$];

	// Lit segments for 0 to F, bit 0 is segment a
	segments_t glyphs [16] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h27,
		7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
	};

	calcTop uut (
		.clk(clk),
		.rstN(rstN),
		.digitStrobe(digitStrobe),
		.digit(digit),
		.opStrobe(opStrobe),
		.opCode(opCode),
		.equalStrobe(equalStrobe),
		.clearStrobe(clearStrobe),
		.segments(segments),
		.anodes(anodes)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and checks
	//////////////////////////////////////////////////////////////////////

	task automatic reportMismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1, "display mismatch");
	endtask

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "run aborted");
	endtask

	task automatic checkValue(input operand_t got, input operand_t expected, input int row);
		if (got !== expected)
			reportMismatch($sformatf("row %0d shows %h, expected %h", row, got, expected));
	endtask

	task automatic checkBlank(input logic [`CALC_DIGITS-1:0] got,
		input logic [`CALC_DIGITS-1:0] expected, input int row);
		if (got !== expected)
			reportMismatch($sformatf("row %0d blank mask %b, expected %b", row, got, expected));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Table construction
	//////////////////////////////////////////////////////////////////////

	// Digit 0 is always lit, others only below the count
	function automatic logic [`CALC_DIGITS-1:0] blankMask(input int count);
		logic [`CALC_DIGITS-1:0] mask;
		mask = '0;
		for (int i = 1; i < `CALC_DIGITS; i++)
			if (i >= count)
				mask[i] = 1'b1;
		return mask;
	endfunction

	task automatic addRow(input keyKind_t kind, input logic [3:0] data, input operand_t value,
		input logic [`CALC_DIGITS-1:0] mask);
		keyRow_t row;
		row.kind = kind;
		row.data = data;
		row.value = value;
		row.blankMask = mask;
		keyTable.push_back(row);
	endtask

	// Digits go in most significant first and the value grows from the right
	task automatic addNumber(input operand_t v, input int count);
		for (int i = count - 1; i >= 0; i--)
			addRow(keyDigit, v[4*i +: 4], v >> (4*i), blankMask(count - i));
	endtask

	task automatic addOp(input opCode_t op, input operand_t shown, input int count);
		addRow(keyOp, {1'b0, op}, shown, blankMask(count));
	endtask

	task automatic addEqual(input operand_t expected);
		addRow(keyEqual, 4'h0, expected, '0);
	endtask

	task automatic buildTable();
		addNumber(32'h123, 3);
		addOp(opAdd, 32'h123, 3);
		addNumber(32'h45, 2);
		addEqual(32'h123 + 32'h45);
		// Each first digit below comes right after a result
		addNumber(32'h5, 1);
		addOp(opSub, 32'h5, 1);
		addNumber(32'h9, 1);
		addEqual(32'h5 - 32'h9);
		addNumber(32'h12345, 5);
		addOp(opMul, 32'h12345, 5);
		addNumber(32'hABCDE, 5);
		addEqual(32'h12345 * 32'hABCDE);
		// Second operator replaces the first
		addNumber(32'hF0F0, 4);
		addOp(opOr, 32'hF0F0, 4);
		addOp(opAnd, 32'hF0F0, 4);
		addNumber(32'h3C3C, 4);
		addEqual(32'hF0F0 & 32'h3C3C);
		addNumber(32'hA0A0A, 5);
		addOp(opOr, 32'hA0A0A, 5);
		addNumber(32'h5050, 4);
		addEqual(32'hA0A0A | 32'h5050);
		// Full operand, then a ninth digit that must drop out
		addNumber(32'h87654321, 8);
		addRow(keyDigit, 4'h9, 32'h87654321, '0);
		addOp(opXor, 32'h87654321, 8);
		addNumber(32'hFFFF0000, 8);
		addEqual(32'h87654321 ^ 32'hFFFF0000);
		// Clear in the middle of an entry
		addNumber(32'h12, 2);
		addRow(keyClear, 4'h0, '0, blankMask(0));
		addNumber(32'h7, 1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Key driving and frame capture
	//////////////////////////////////////////////////////////////////////

	task automatic pressKey(input keyRow_t row);
		@(posedge clk);
		#driveDelay;
		case (row.kind)
			keyDigit:
			begin
				digit = row.data;
				digitStrobe = 1'b1;
			end
			keyOp:
			begin
				opCode = opCode_t'(row.data[2:0]);
				opStrobe = 1'b1;
			end
			keyEqual:
				equalStrobe = 1'b1;
			default:
				clearStrobe = 1'b1;
		endcase
		@(posedge clk);
		#driveDelay;
		digitStrobe = 1'b0;
		opStrobe = 1'b0;
		equalStrobe = 1'b0;
		clearStrobe = 1'b0;
	endtask

	// Sampled on the falling edge, away from the scanner's updates
	task automatic captureFrame(output operand_t value, output logic [`CALC_DIGITS-1:0] blank);
		int waited;
		logic found;
		value = '0;
		blank = '0;
		for (int i = 0; i < `CALC_DIGITS; i++)
		begin
			waited = 0;
			@(negedge clk);
			while (anodes[i] !== 1'b0)
			begin
				if (waited >= 2 * frameCycles)
					abortRun($sformatf("Timed out waiting for anode %0d to be driven", i));
				@(negedge clk);
				waited++;
			end
			if (segments === 7'h7F)
				blank[i] = 1'b1;
			else
			begin
				found = 1'b0;
				for (int n = 0; n < 16; n++)
				begin
					if (segments === ~glyphs[n])
					begin
						value[4*i +: 4] = n[3:0];
						found = 1'b1;
					end
				end
				if (!found)
					abortRun($sformatf("Digit %0d shows an unknown segment pattern %b",
						i, segments));
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		operand_t shown;
		logic [`CALC_DIGITS-1:0] blank;
		rstN = 1'b0;
		digitStrobe = 1'b0;
		digit = '0;
		opStrobe = 1'b0;
		opCode = opAdd;
		equalStrobe = 1'b0;
		clearStrobe = 1'b0;
		buildTable();

		repeat (8) @(posedge clk);
		#driveDelay;
		rstN = 1'b1;

		// Reset display is a single 0
		repeat (2 * frameCycles) @(posedge clk);
		captureFrame(shown, blank);
		checkValue(shown, '0, -1);
		checkBlank(blank, blankMask(0), -1);

		foreach (keyTable[r])
		begin
			pressKey(keyTable[r]);
			repeat (2 * frameCycles) @(posedge clk);
			captureFrame(shown, blank);
			checkValue(shown, keyTable[r].value, r);
			checkBlank(blank, keyTable[r].blankMask, r);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- logic/calcTop.sv
`timescale 1ns/1ps
`include "calc_consts.svh"

module calcTop import calcPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic digitStrobe,
	input nibble_t digit,
	input logic opStrobe,
	input opCode_t opCode,
	input logic equalStrobe,
	input logic clearStrobe,
	output segments_t segments,
	output logic [`CALC_DIGITS-1:0] anodes
);

	calcMode_t mode;
	calcCmd_t cmd;
	operand_t operandA;
	operand_t operandB;
	operand_t result;
	opCode_t heldOp;
	digitSlot_t [`CALC_DIGITS-1:0] slots;
	segments_t [`CALC_DIGITS-1:0] segArray;

	//////////////////////////////////////////////////////////////////////
	// Entry and arithmetic
	//////////////////////////////////////////////////////////////////////

	entryControl controlInst (
		.clk(clk),
		.rstN(rstN),
		.digitStrobe(digitStrobe),
		.opStrobe(opStrobe),
		.equalStrobe(equalStrobe),
		.clearStrobe(clearStrobe),
		.mode(mode),
		.cmd(cmd)
	);

	operandMemory memoryInst (
		.clk(clk),
		.rstN(rstN),
		.mode(mode),
		.cmd(cmd),
		.digit(digit),
		.opCode(opCode),
		.result(result),
		.operandA(operandA),
		.operandB(operandB),
		.heldOp(heldOp),
		.slots(slots)
	);

	calcAlu aluInst (
		.operandA(operandA),
		.operandB(operandB),
		.op(heldOp),
		.result(result)
	);

	//////////////////////////////////////////////////////////////////////
	// Display path
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `CALC_DIGITS; i++)
	begin : decoderGen
		segmentDecoder decoderInst (
			.slot(slots[i]),
			.segs(segArray[i])
		);
	end

	displayScanner scannerInst (
		.clk(clk),
		.rstN(rstN),
		.segArray(segArray),
		.segments(segments),
		.anodes(anodes)
	);

endmodule

//--- logic/displayScanner.sv
`timescale 1ns/1ps
`include "calc_consts.svh"

module displayScanner import calcPkg::*;
#(
	parameter int scanTicks = `SCAN_TICKS
)
(
	input logic clk,
	input logic rstN,
	input segments_t [`CALC_DIGITS-1:0] segArray,
	output segments_t segments,
	output logic [`CALC_DIGITS-1:0] anodes
);

	localparam int dwellBits = (scanTicks > 1) ? $clog2(scanTicks) : 1;
	localparam int indexBits = $clog2(`CALC_DIGITS);
	localparam logic [indexBits-1:0] lastIndex = indexBits'(`CALC_DIGITS - 1);

	logic [dwellBits-1:0] dwell;
	logic [indexBits-1:0] digitIndex;
	logic [`CALC_DIGITS-1:0] anodeSel;

	always_comb
	begin
		anodeSel = '1;
		anodeSel[digitIndex] = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Scan sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			dwell <= '0;
			digitIndex <= '0;
			segments <= '1;
			anodes <= '1;
		end
		else
		begin
			segments <= segArray[digitIndex];
			anodes <= anodeSel;
			if (dwell == dwellBits'(scanTicks - 1))
			begin
				dwell <= '0;
				digitIndex <= (digitIndex == lastIndex) ? '0 : digitIndex + 1'b1;
			end
			else
				dwell <= dwell + 1'b1;
		end
	end

	// Never more than one digit driven at a time
	assert property (@(posedge clk) disable iff (!rstN) $onehot0(~anodes));

endmodule

//--- logic/segmentDecoder.sv
`timescale 1ns/1ps

module segmentDecoder import calcPkg::*;
(
	input digitSlot_t slot,
	output segments_t segs
);

	// Lit segments, active high, bit order g down to a
	segments_t lit;

	always_comb
	begin
		case (slot.nibble)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h27;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
	end

	// Pins are active low; blank turns every segment off
	assign segs = slot.blank ? '1 : ~lit;

endmodule

//--- logic/calcAlu.sv
`timescale 1ns/1ps

module calcAlu import calcPkg::*;
(
	input operand_t operandA,
	input operand_t operandB,
	input opCode_t op,
	output operand_t result
);

	//////////////////////////////////////////////////////////////////////
	// Operator select
	//////////////////////////////////////////////////////////////////////

	// Everything wraps at the operand width, no carry or overflow kept
	always_comb
	begin
		case (op)
			opAdd:
				result = operandA + operandB;
			opSub:
				result = operandA - operandB;
			opMul:
				// Low word of the product
				result = operand_t'(operandA * operandB);
			opAnd:
				result = operandA & operandB;
			opOr:
				result = operandA | operandB;
			opXor:
				result = operandA ^ operandB;
			default:
				result = '0;
		endcase
	end

endmodule

//--- logic/operandMemory.sv
`timescale 1ns/1ps
`include "calc_consts.svh"

module operandMemory import calcPkg::*;
(
	input logic clk,
	input logic rstN,
	input calcMode_t mode,
	input calcCmd_t cmd,
	input nibble_t digit,
	input opCode_t opCode,
	input operand_t result,
	output operand_t operandA,
	output operand_t operandB,
	output opCode_t heldOp,
	output digitSlot_t [`CALC_DIGITS-1:0] slots
);

	localparam digitCount_t fullCount = digitCount_t'(`CALC_DIGITS);

	digitCount_t countA;
	digitCount_t countB;
	operand_t nextA;
	operand_t nextB;
	digitCount_t nextCountA;
	digitCount_t nextCountB;
	opCode_t nextOp;
	operand_t shownValue;
	digitCount_t shownCount;

	//////////////////////////////////////////////////////////////////////
	// Register update
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Clear first, so a load in the same cycle starts from zero
		nextA = cmd.clearAll ? '0 : operandA;
		nextB = cmd.clearAll ? '0 : operandB;
		nextCountA = cmd.clearAll ? '0 : countA;
		nextCountB = cmd.clearAll ? '0 : countB;
		nextOp = cmd.clearAll ? opAdd : heldOp;

		// Digits past the eighth drop out here
		if (cmd.loadFirst && nextCountA < fullCount)
		begin
			nextA = {nextA[`CALC_WIDTH-5:0], digit};
			nextCountA = nextCountA + 1'b1;
		end
		if (cmd.loadSecond && nextCountB < fullCount)
		begin
			nextB = {nextB[`CALC_WIDTH-5:0], digit};
			nextCountB = nextCountB + 1'b1;
		end
		if (cmd.loadOp)
			nextOp = opCode;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			operandA <= '0;
			operandB <= '0;
			countA <= '0;
			countB <= '0;
			heldOp <= opAdd;
		end
		else
		begin
			operandA <= nextA;
			operandB <= nextB;
			countA <= nextCountA;
			countB <= nextCountB;
			heldOp <= nextOp;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Display selection
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (mode)
			modeSecond:
			begin
				shownValue = operandB;
				shownCount = countB;
			end
			modeResult:
			begin
				shownValue = result;
				shownCount = fullCount;
			end
			default:
			begin
				shownValue = operandA;
				shownCount = countA;
			end
		endcase
	end

	// Digit 0 stays lit so an empty operand reads as 0
	for (genvar i = 0; i < `CALC_DIGITS; i++)
	begin : slotGen
		assign slots[i].nibble = shownValue[4*i +: 4];
		assign slots[i].blank = (i != 0) && (i >= shownCount);
	end

	assert property (@(posedge clk) disable iff (!rstN)
		countA <= fullCount && countB <= fullCount);

endmodule

//--- logic/entryControl.sv
`timescale 1ns/1ps

module entryControl import calcPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic digitStrobe,
	input logic opStrobe,
	input logic equalStrobe,
	input logic clearStrobe,
	output calcMode_t mode,
	output calcCmd_t cmd
);

	// A digit after a result wipes the memory and starts a new first operand
	localparam calcCmd_t restartCmd = '{
		loadFirst: 1'b1,
		loadSecond: 1'b0,
		loadOp: 1'b0,
		clearAll: 1'b1
	};

	calcMode_t nextMode;

	//////////////////////////////////////////////////////////////////////
	// Command decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		cmd = '0;
		nextMode = mode;
		if (clearStrobe)
		begin
			cmd.clearAll = 1'b1;
			nextMode = modeFirst;
		end
		else
		begin
			case (mode)
				modeFirst:
				begin
					if (digitStrobe)
						cmd.loadFirst = 1'b1;
					else if (opStrobe)
					begin
						cmd.loadOp = 1'b1;
						nextMode = modeOp;
					end
				end
				modeOp:
				begin
					if (digitStrobe)
					begin
						cmd.loadSecond = 1'b1;
						nextMode = modeSecond;
					end
					else if (opStrobe)
						cmd.loadOp = 1'b1;
				end
				modeSecond:
				begin
					if (digitStrobe)
						cmd.loadSecond = 1'b1;
					else if (equalStrobe)
						nextMode = modeResult;
				end
				default:
				begin
					// Operators are ignored while a result is shown
					if (digitStrobe)
					begin
						cmd = restartCmd;
						nextMode = modeFirst;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			mode <= modeFirst;
		else
			mode <= nextMode;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Only the restart may raise two commands, and it always lands in modeFirst
	assert property (@(posedge clk) disable iff (!rstN)
		!$onehot0(cmd) |-> (mode == modeResult && cmd == restartCmd) ##1 mode == modeFirst);

	assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({digitStrobe, opStrobe, equalStrobe, clearStrobe}));

endmodule

//--- logic/calcPkg.sv
`include "calc_consts.svh"

package calcPkg;

	//////////////////////////////////////////////////////////////////////
	// Value widths
	//////////////////////////////////////////////////////////////////////

	typedef logic [`CALC_WIDTH-1:0] operand_t;
	typedef logic [3:0] nibble_t;
	// Digits entered so far, 0 to 8
	typedef logic [3:0] digitCount_t;
	// Active low, bit 0 is segment a
	typedef logic [6:0] segments_t;

	//////////////////////////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		opAdd,
		opSub,
		opMul,
		opAnd,
		opOr,
		opXor
	} opCode_t;

	typedef enum logic [1:0] {
		modeFirst,
		modeOp,
		modeSecond,
		modeResult
	} calcMode_t;

	// Commands from the controller to the operand memory
	typedef struct packed {
		logic loadFirst;
		logic loadSecond;
		logic loadOp;
		logic clearAll;
	} calcCmd_t;

	typedef struct packed {
		logic blank;
		nibble_t nibble;
	} digitSlot_t;

endpackage

//--- logic/calc_consts.svh
`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Calculator sizing
//////////////////////////////////////////////////////////////////////

// Operand and result width in bits
`define CALC_WIDTH 32

// Hex digits on the display, one per nibble of an operand
`define CALC_DIGITS 8

// Clock cycles each display digit stays lit
`define SCAN_TICKS 4

`endif
